/* hw/bp_btb.sv */
`timescale 1ns/1ps

module bp_btb #(
    parameter int BTB_ROWS = 16                          // power of two
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [bp_pkg::xlen-1:0] pc_f,                // fetch pc
    input  logic                    bp_enable,           // level from control regs
    input  logic                    bp_flush,            // one-cycle pulse
    input  logic                    upd_valid,           // strobe from resolve
    input  logic [bp_pkg::xlen-1:0] upd_pc,
    input  logic [bp_pkg::xlen-1:0] upd_target,
    input  logic                    upd_taken,
    input  logic                    upd_uncond,          // jal
    input  logic                    upd_is_branch,       // conditional branch
    output logic                    predict_taken,
    output logic [bp_pkg::xlen-1:0] next_pc
);

    import bp_pkg::*;

    localparam int idx_w = $clog2(BTB_ROWS);             // row select width
    localparam int tag_w = xlen - idx_w - 2;             // pc bits above the index

    // row storage
    logic [BTB_ROWS-1:0] valid_q;
    logic [tag_w-1:0]    tag_q    [BTB_ROWS];
    logic [xlen-1:0]     target_q [BTB_ROWS];
    logic [1:0]          ctr_q    [BTB_ROWS];
    logic                uncond_q [BTB_ROWS];

    // fetch side
    logic [idx_w-1:0] idx_f;
    logic [tag_w-1:0] tag_f;
    logic             hit_f;

    // update side
    logic [idx_w-1:0] idx_u;
    logic [tag_w-1:0] tag_u;
    logic             hit_u;
    logic [1:0]       ctr_cur;
    logic [1:0]       ctr_next;

    // zero-latency lookup
    assign idx_f = pc_f[idx_w+1:2];                      // word offset skipped
    assign tag_f = pc_f[xlen-1:idx_w+2];
    assign hit_f = valid_q[idx_f] && (tag_q[idx_f] == tag_f);

    // uncond rows always predict taken and others follow the counter msb
    assign predict_taken = bp_enable && hit_f && (uncond_q[idx_f] || ctr_q[idx_f][1]);
    assign next_pc       = predict_taken ? target_q[idx_f] : pc_f + xlen'(4);

    // update indexes by the branch's own pc like the lookup
    assign idx_u = upd_pc[idx_w+1:2];
    assign tag_u = upd_pc[xlen-1:idx_w+2];
    assign hit_u = valid_q[idx_u] && (tag_q[idx_u] == tag_u);

    assign ctr_cur = ctr_q[idx_u];

    always_comb begin
        ctr_next = ctr_cur;                              // hold by default
        if (upd_taken) begin
            if (ctr_cur != 2'b11) begin
                ctr_next = ctr_cur + 2'b01;              // step toward strong taken
            end
        end else begin
            if (ctr_cur != 2'b00) begin
                ctr_next = ctr_cur - 2'b01;              // step toward strong not taken
            end
        end
    end

    // flush wins over a same-cycle update
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= '0;
        end else if (bp_flush) begin
            valid_q <= '0;                               // drop every row
        end else if (upd_valid && !hit_u && upd_taken) begin
            valid_q[idx_u] <= 1'b1;                      // allocate on taken miss
        end
    end

    // row payload
    always_ff @(posedge clk) begin
        if (upd_valid && !bp_flush) begin
            if (hit_u) begin
                if (upd_taken) begin
                    target_q[idx_u] <= upd_target;       // refresh on taken
                end
                if (upd_is_branch) begin
                    ctr_q[idx_u] <= ctr_next;            // jal rows keep their counter
                end
            end else if (upd_taken) begin
                tag_q[idx_u]    <= tag_u;                // new row replaces any old owner
                target_q[idx_u] <= upd_target;
                ctr_q[idx_u]    <= ctr_wn;
                uncond_q[idx_u] <= upd_uncond;
            end
        end
    end

    // resolve strobe must be clean at every edge
    a_upd_known : assert property (@(posedge clk) disable iff (!rst)
        !$isunknown(upd_valid))
        else $error("upd_valid unknown");

    // control regs give a single-cycle flush
    a_flush_pulse : assert property (@(posedge clk) disable iff (!rst)
        bp_flush |=> !bp_flush)
        else $error("bp_flush held for two cycles");

endmodule

/* hw/bp_ctrl_regs.sv */
`timescale 1ns/1ps

module bp_ctrl_regs (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cfg_wr,              // write strobe
    input  logic [1:0]              cfg_addr,
    input  logic [bp_pkg::xlen-1:0] cfg_wdata,
    input  logic                    stat_branch,         // one resolved b-type or jal
    input  logic                    stat_mispredict,
    output logic [bp_pkg::xlen-1:0] cfg_rdata,
    output logic                    bp_enable,
    output logic                    bp_flush
);

    import bp_pkg::*;

    logic [xlen-1:0] cnt_br;                             // resolved branches
    logic [xlen-1:0] cnt_mp;                             // mispredicts
    logic            wr_ctrl;
    logic            wr_br;
    logic            wr_mp;

    assign wr_ctrl = cfg_wr && (cfg_addr == reg_ctrl);
    assign wr_br   = cfg_wr && (cfg_addr == reg_branches);
    assign wr_mp   = cfg_wr && (cfg_addr == reg_mispredicts);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            bp_enable <= 1'b1;                           // predictor on out of reset
            bp_flush  <= 1'b0;
            cnt_br    <= '0;
            cnt_mp    <= '0;
        end else begin
            bp_flush <= wr_ctrl && cfg_wdata[1];         // self-clears next cycle
            if (wr_ctrl) begin
                bp_enable <= cfg_wdata[0];
            end
            if (wr_br) begin
                cnt_br <= '0;                            // any write clears
            end else if (stat_branch && (cnt_br != '1)) begin
                cnt_br <= cnt_br + 1'b1;                 // saturate at all ones
            end
            if (wr_mp) begin
                cnt_mp <= '0;
            end else if (stat_mispredict && (cnt_mp != '1)) begin
                cnt_mp <= cnt_mp + 1'b1;
            end
        end
    end

    // flush bit reads back as zero
    always_comb begin
        case (cfg_addr)
            reg_ctrl:        cfg_rdata = {{(xlen-1){1'b0}}, bp_enable};
            reg_branches:    cfg_rdata = cnt_br;
            reg_mispredicts: cfg_rdata = cnt_mp;
            default:         cfg_rdata = '0;             // unmapped
        endcase
    end

    a_addr_known : assert property (@(posedge clk) disable iff (!rst)
        cfg_wr |-> !$isunknown(cfg_addr))
        else $error("cfg_addr unknown during write");

endmodule

/* hw/bp_pkg.sv */
package bp_pkg;

    localparam int xlen = 32;                        // instruction and address width

    // major opcodes of the predicted control-flow instructions
    localparam logic [6:0] op_branch = 7'b1100011;   // beq, bne, blt, bge, bltu, bgeu
    localparam logic [6:0] op_jal    = 7'b1101111;   // jal, always taken

    // 2-bit saturating counter, msb set means predict taken
    // 00 strong not taken, 01 weak not taken, 10 weak taken, 11 strong taken
    localparam logic [1:0] ctr_wn = 2'b10;            // start value of a new conditional row

    // control register map
    localparam logic [1:0] reg_ctrl        = 2'd0;   // bit 0 enable, bit 1 flush
    localparam logic [1:0] reg_branches    = 2'd1;   // resolved branch count
    localparam logic [1:0] reg_mispredicts = 2'd2;   // mispredict count

    // one instruction word, read either as B-type or as J-type
    typedef union packed {
        struct packed {
            logic       imm12;                       // sign bit of the offset
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;                      // compare kind
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic       imm20;                       // sign bit of the offset
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;                          // link register
            logic [6:0] opcode;
        } j;
    } instr_word_t;

endpackage

/* hw/bp_resolve.sv */
`timescale 1ns/1ps

module bp_resolve (
    input  logic                    ex_valid,            // retiring instr strobe
    input  logic [bp_pkg::xlen-1:0] pc_ex,
    input  logic [bp_pkg::xlen-1:0] instr_ex,
    input  logic                    cond_taken,          // execute compare result
    input  logic                    pred_taken_ex,       // prediction carried down the pipe
    input  logic [bp_pkg::xlen-1:0] pred_target_ex,
    output logic                    mispredict,
    output logic [bp_pkg::xlen-1:0] redirect_pc,
    output logic                    upd_valid,
    output logic [bp_pkg::xlen-1:0] upd_pc,
    output logic [bp_pkg::xlen-1:0] upd_target,
    output logic                    upd_taken,
    output logic                    upd_uncond,
    output logic                    upd_is_branch,
    output logic                    stat_branch,
    output logic                    stat_mispredict
);

    import bp_pkg::*;

    instr_word_t     iw;
    logic            is_br;
    logic            is_jal;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_j;
    logic [xlen-1:0] act_target;
    logic            act_taken;
    logic [xlen-1:0] seq_pc;

    assign iw = instr_ex;

    // funct3 010 and 011 are not valid branch compares
    assign is_br  = (iw.b.opcode == op_branch) && (iw.b.funct3[2:1] != 2'b01);
    assign is_jal = (iw.j.opcode == op_jal);

    // offsets are in halfwords so bit 0 is always zero
    assign imm_b = {{19{iw.b.imm12}}, iw.b.imm12, iw.b.imm11, iw.b.imm10_5,
                    iw.b.imm4_1, 1'b0};
    assign imm_j = {{11{iw.j.imm20}}, iw.j.imm20, iw.j.imm19_12, iw.j.imm11,
                    iw.j.imm10_1, 1'b0};

    assign seq_pc = pc_ex + xlen'(4);

    always_comb begin
        act_target = pc_ex + (is_jal ? imm_j : imm_b);
        act_taken  = is_jal || (is_br && cond_taken);    // anything else falls through

        // wrong direction or taken both ways to different places
        mispredict = ex_valid && ((act_taken != pred_taken_ex) ||
                     (act_taken && (pred_target_ex != act_target)));
        redirect_pc = act_taken ? act_target : seq_pc;

        // only b-type and jal train the buffer
        upd_valid     = ex_valid && (is_br || is_jal);
        upd_pc        = pc_ex;
        upd_target    = act_target;
        upd_taken     = act_taken;
        upd_uncond    = is_jal;
        upd_is_branch = is_br;

        stat_branch     = upd_valid;
        stat_mispredict = mispredict;
    end

endmodule

/* hw/bp_top.sv */
`timescale 1ns/1ps

module bp_top #(
    parameter int BTB_ROWS = 16                          // buffer depth
) (
    input  logic                    clk,
    input  logic                    rst,
    // fetch
    input  logic [bp_pkg::xlen-1:0] pc_f,
    output logic                    predict_taken,
    output logic [bp_pkg::xlen-1:0] next_pc,
    // execute
    input  logic                    ex_valid,
    input  logic [bp_pkg::xlen-1:0] pc_ex,
    input  logic [bp_pkg::xlen-1:0] instr_ex,
    input  logic                    cond_taken,
    input  logic                    pred_taken_ex,
    input  logic [bp_pkg::xlen-1:0] pred_target_ex,
    output logic                    mispredict,
    output logic [bp_pkg::xlen-1:0] redirect_pc,
    // config
    input  logic                    cfg_wr,
    input  logic [1:0]              cfg_addr,
    input  logic [bp_pkg::xlen-1:0] cfg_wdata,
    output logic [bp_pkg::xlen-1:0] cfg_rdata
);

    import bp_pkg::*;

    logic            bp_enable;
    logic            bp_flush;
    logic            upd_valid;
    logic [xlen-1:0] upd_pc;
    logic [xlen-1:0] upd_target;
    logic            upd_taken;
    logic            upd_uncond;
    logic            upd_is_branch;
    logic            stat_branch;
    logic            stat_mispredict;

    bp_btb #(.BTB_ROWS(BTB_ROWS)) u_btb (.*);            // lookup and training

    bp_resolve u_resolve (.*);                           // execute-side outcome

    bp_ctrl_regs u_regs (.*);                            // enable, flush, counters

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module bp_tb \
    -f sim.f \
    -o bp_tb_sim

./obj_dir/bp_tb_sim

/* sim.f */
+incdir+tb
hw/bp_pkg.sv
hw/bp_btb.sv
hw/bp_resolve.sv
hw/bp_ctrl_regs.sv
hw/bp_top.sv
tb/bp_tb.sv

/* tb/bp_vectors.svh */
// columns: kind, pc (cfg address for k_wr and k_rd), word (instruction or cfg data),
// cond_taken, pred_taken_ex, pred_target_ex, expected bit, expected word

localparam logic [31:0] pc_a  = 32'h0000_1000;           // buffer row 0
localparam logic [31:0] pc_j  = 32'h0000_1008;           // buffer row 2
localparam logic [31:0] pc_x  = 32'h0000_2000;           // row 0 again, other tag
localparam logic [31:0] pc_c  = 32'h0000_1010;           // buffer row 4
localparam logic [31:0] off_a = -32'sh0000_0a48;         // backward branch
localparam logic [31:0] off_j = -32'sh0007_f804;         // touches every j field
localparam logic [31:0] off_x = 32'h0000_0100;
localparam logic [31:0] off_c = 32'h0000_0020;
localparam logic [31:0] ta    = pc_a + off_a;            // actual targets, pc plus offset
localparam logic [31:0] tj    = pc_j + off_j;
localparam logic [31:0] tx    = pc_x + off_x;
localparam logic [31:0] tc    = pc_c + off_c;

task automatic fill_table();
    logic [31:0] wa;
    logic [31:0] wj;
    logic [31:0] wx;
    logic [31:0] wc;
    wa = b_type(off_a[12:0]);
    wj = jal_word(off_j[20:0]);
    wx = b_type(off_x[12:0]);
    wc = b_type(off_c[12:0]);
    // empty buffer after reset
    tbl.push_back(vec_t'{k_look, pc_a, '0, 1'b0, 1'b0, '0, 1'b0, pc_a + 32'd4});
    tbl.push_back(vec_t'{k_fill, '0, '0, 1'b0, 1'b0, '0, 1'b0, '0});
    tbl.push_back(vec_t'{k_fill, '0, '0, 1'b0, 1'b0, '0, 1'b0, '0});
    // conditional branch, counter walks 10 11 10 01 10
    tbl.push_back(vec_t'{k_res, pc_a, wa, 1'b1, 1'b0, '0, 1'b1, ta});
    tbl.push_back(vec_t'{k_look, pc_a, '0, 1'b0, 1'b0, '0, 1'b1, ta});
    tbl.push_back(vec_t'{k_res, pc_a, wa, 1'b1, 1'b1, ta, 1'b0, ta});
    tbl.push_back(vec_t'{k_res, pc_a, wa, 1'b0, 1'b1, ta, 1'b1, pc_a + 32'd4});
    tbl.push_back(vec_t'{k_look, pc_a, '0, 1'b0, 1'b0, '0, 1'b1, ta});
    tbl.push_back(vec_t'{k_res, pc_a, wa, 1'b0, 1'b1, ta, 1'b1, pc_a + 32'd4});
    tbl.push_back(vec_t'{k_look, pc_a, '0, 1'b0, 1'b0, '0, 1'b0, pc_a + 32'd4});
    tbl.push_back(vec_t'{k_res, pc_a, wa, 1'b1, 1'b0, '0, 1'b1, ta});
    tbl.push_back(vec_t'{k_look, pc_a, '0, 1'b0, 1'b0, '0, 1'b1, ta});
    // jal, taken whatever the compare says
    tbl.push_back(vec_t'{k_res, pc_j, wj, 1'b0, 1'b0, '0, 1'b1, tj});
    tbl.push_back(vec_t'{k_look, pc_j, '0, 1'b0, 1'b0, '0, 1'b1, tj});
    tbl.push_back(vec_t'{k_res, pc_j, wj, 1'b0, 1'b1, tj, 1'b0, tj});
    tbl.push_back(vec_t'{k_look, pc_j, '0, 1'b0, 1'b0, '0, 1'b1, tj});
    // same row, other tag, replaces branch a
    tbl.push_back(vec_t'{k_look, pc_x, '0, 1'b0, 1'b0, '0, 1'b0, pc_x + 32'd4});
    tbl.push_back(vec_t'{k_res, pc_x, wx, 1'b1, 1'b0, '0, 1'b1, tx});
    tbl.push_back(vec_t'{k_look, pc_x, '0, 1'b0, 1'b0, '0, 1'b1, tx});
    tbl.push_back(vec_t'{k_look, pc_a, '0, 1'b0, 1'b0, '0, 1'b0, pc_a + 32'd4});
    // correct prediction, then a wrong target
    tbl.push_back(vec_t'{k_res, pc_c, wc, 1'b1, 1'b0, '0, 1'b1, tc});
    tbl.push_back(vec_t'{k_res, pc_c, wc, 1'b1, 1'b1, tc, 1'b0, tc});
    tbl.push_back(vec_t'{k_res, pc_c, wc, 1'b1, 1'b1, tc + 32'd8, 1'b1, tc});
    tbl.push_back(vec_t'{k_look, pc_c, '0, 1'b0, 1'b0, '0, 1'b1, tc});
    // 11 resolves so far, 8 of them mispredicted
    tbl.push_back(vec_t'{k_rd, 32'(reg_branches), '0, 1'b0, 1'b0, '0, 1'b0, 32'd11});
    tbl.push_back(vec_t'{k_rd, 32'(reg_mispredicts), '0, 1'b0, 1'b0, '0, 1'b0, 32'd8});
    tbl.push_back(vec_t'{k_wr, 32'(reg_ctrl), 32'd0, 1'b0, 1'b0, '0, 1'b0, '0});
    tbl.push_back(vec_t'{k_rd, 32'(reg_ctrl), '0, 1'b0, 1'b0, '0, 1'b0, 32'd0});
    tbl.push_back(vec_t'{k_look, pc_c, '0, 1'b0, 1'b0, '0, 1'b0, pc_c + 32'd4});
    // flush while disabled, then enable again
    tbl.push_back(vec_t'{k_wr, 32'(reg_ctrl), 32'd2, 1'b0, 1'b0, '0, 1'b0, '0});
    tbl.push_back(vec_t'{k_wr, 32'(reg_ctrl), 32'd1, 1'b0, 1'b0, '0, 1'b0, '0});
    tbl.push_back(vec_t'{k_look, pc_c, '0, 1'b0, 1'b0, '0, 1'b0, pc_c + 32'd4});
    tbl.push_back(vec_t'{k_look, pc_j, '0, 1'b0, 1'b0, '0, 1'b0, pc_j + 32'd4});
    tbl.push_back(vec_t'{k_fill, '0, '0, 1'b0, 1'b0, '0, 1'b0, '0});
    tbl.push_back(vec_t'{k_wr, 32'(reg_branches), 32'd0, 1'b0, 1'b0, '0, 1'b0, '0});
    tbl.push_back(vec_t'{k_rd, 32'(reg_branches), '0, 1'b0, 1'b0, '0, 1'b0, 32'd0});
    tbl.push_back(vec_t'{k_rd, 32'(reg_mispredicts), '0, 1'b0, 1'b0, '0, 1'b0, 32'd8});
endtask

/* tb/bp_tb.sv */
`timescale 1ns/1ps

module bp_tb;

    import bp_pkg::*;

    typedef enum logic [2:0] {k_look, k_fill, k_res, k_wr, k_rd} kind_t;

    // one table row
    typedef struct packed {
        kind_t       kind;
        logic [31:0] pc;                                  // cfg address on k_wr and k_rd
        logic [31:0] word;                                // instruction or cfg data
        logic        cond;
        logic        ptaken;
        logic [31:0] ptarget;
        logic        exp_bit;                             // predict_taken or mispredict
        logic [31:0] exp_word;                            // next_pc, redirect_pc or cfg_rdata
    } vec_t;

    localparam int edge_limit = 8;                        // clock changes allowed per wait

    logic            clk = 1'b0;
    logic            rst;
    logic [xlen-1:0] pc_f;
    logic            predict_taken;
    logic [xlen-1:0] next_pc;
    logic            ex_valid;
    logic [xlen-1:0] pc_ex;
    logic [xlen-1:0] instr_ex;
    logic            cond_taken;
    logic            pred_taken_ex;
    logic [xlen-1:0] pred_target_ex;
    logic            mispredict;
    logic [xlen-1:0] redirect_pc;
    logic            cfg_wr;
    logic [1:0]      cfg_addr;
    logic [xlen-1:0] cfg_wdata;
    logic [xlen-1:0] cfg_rdata;

    vec_t tbl[$];
    int   seed = 32'h3697;                                // filler pc source

    bp_top #(.BTB_ROWS(16)) uut (.*);

    initial begin
        forever #2 clk = ~clk;                            // 4 ns period
    end

    // bne x5, x6 with the given halfword offset
    function automatic logic [31:0] b_type(input logic [12:0] off);
        instr_word_t w;
        w = '0;
        w.b.imm12   = off[12];
        w.b.imm11   = off[11];
        w.b.imm10_5 = off[10:5];
        w.b.imm4_1  = off[4:1];
        w.b.rs1     = 5'd5;
        w.b.rs2     = 5'd6;
        w.b.funct3  = 3'b001;
        w.b.opcode  = op_branch;
        return w;
    endfunction

    // jal ra with the given offset
    function automatic logic [31:0] jal_word(input logic [20:0] off);
        instr_word_t w;
        w = '0;
        w.j.imm20    = off[20];
        w.j.imm19_12 = off[19:12];
        w.j.imm11    = off[11];
        w.j.imm10_1  = off[10:1];
        w.j.rd       = 5'd1;
        w.j.opcode   = op_jal;
        return w;
    endfunction

    `include "bp_vectors.svh"

    // returns on the next falling edge
    task automatic wait_fall();
        int edges;
        edges = 0;
        @(clk);
        while (clk !== 1'b0 && edges < edge_limit) begin
            @(clk);
            edges++;
        end
        if (clk !== 1'b0) begin
            $display("Testbench failed");
            $fatal(1, "no falling clock edge within %0d clock changes", edge_limit);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] time %0d ns: %s expected %h, got %h", $time, name, exp, got);
            $display("Testbench failed");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic drive_idle();
        pc_f           = '0;
        ex_valid       = 1'b0;
        pc_ex          = '0;
        instr_ex       = '0;
        cond_taken     = 1'b0;
        pred_taken_ex  = 1'b0;
        pred_target_ex = '0;
        cfg_wr         = 1'b0;
        cfg_addr       = reg_ctrl;
        cfg_wdata      = '0;
    endtask

    // drives one row on the falling edge and checks in the low phase
    task automatic apply_row(input vec_t v);
        if (v.kind == k_fill) begin
            v.pc       = ($random(seed) & 32'hffff_ffc0) | 32'h0000_003c;  // row 15 only
            v.exp_bit  = 1'b0;
            v.exp_word = v.pc + 32'd4;
            v.kind     = k_look;
        end
        drive_idle();
        case (v.kind)
            k_look: pc_f = v.pc;
            k_res: begin
                ex_valid       = 1'b1;
                pc_ex          = v.pc;
                instr_ex       = v.word;
                cond_taken     = v.cond;
                pred_taken_ex  = v.ptaken;
                pred_target_ex = v.ptarget;
            end
            k_wr: begin
                cfg_wr    = 1'b1;
                cfg_addr  = v.pc[1:0];
                cfg_wdata = v.word;
            end
            default: cfg_addr = v.pc[1:0];
        endcase
        #1;                                               // half a low phase so outputs settle
        case (v.kind)
            k_look: begin
                check_value("predict_taken", 32'(predict_taken), 32'(v.exp_bit));
                check_value("next_pc", next_pc, v.exp_word);
                check_value("mispredict", 32'(mispredict), 32'd0);
            end
            k_res: begin
                check_value("mispredict", 32'(mispredict), 32'(v.exp_bit));
                check_value("redirect_pc", redirect_pc, v.exp_word);
            end
            k_rd: check_value("cfg_rdata", cfg_rdata, v.exp_word);
            default: ;
        endcase
    endtask

    initial begin
        drive_idle();
        rst = 1'b0;
        fill_table();
        repeat (5) wait_fall();
        rst = 1'b1;
        foreach (tbl[i]) begin
            wait_fall();
            apply_row(tbl[i]);
        end
        wait_fall();
        $display("Testbench passed");
        $finish;
    end

endmodule
